// ==== tb.f ====
+incdir+logic
logic/ldb_pkg.sv
logic/ldb_cycle_decode.sv
logic/ldb_cycle_queue.sv
logic/ldb_bus_sequencer.sv
logic/ldb_ctl_top.sv
sim/ldb_ctl_sva.sv
sim/tb_ldb_ctl.sv

// ==== Bender.yml ====
package:
  name: ldb_ctl

export_include_dirs:
  - logic

sources:
  - logic/ldb_pkg.sv
  - logic/ldb_cycle_decode.sv
  - logic/ldb_cycle_queue.sv
  - logic/ldb_bus_sequencer.sv
  - logic/ldb_ctl_top.sv
  - target: simulation
    files:
      - sim/ldb_ctl_sva.sv
      - sim/tb_ldb_ctl.sv

// ==== sim/tb_ldb_ctl.sv ====
/*
  LDB controller testbench
  Drives CPU cycles, models local memory and the system bus,
  and checks responses against a reference model
*/
`timescale 1ns/1ps
`include "ldb_settings.svh"

module tb_ldb_ctl;
  import ldb_pkg::*;

  localparam int        CLK_HALF    = 2;        // 4 ns period
  localparam int        MAX_GNT     = 6;        // Longest grant delay
  localparam int        MAX_RDY     = 8;        // Longest ready delay
  localparam int        N_REQ       = 106;      // Requests over all tests
  localparam ldb_addr_t ABSENT_BASE = 16'hf000; // No bus target from here up
  localparam int        WDOG_CYC    = N_REQ * (`LDB_BUS_TIMEOUT + MAX_GNT + 10) + 20;

  logic clk = 1'b0;
  logic rst_n = 1'b0;
  logic cpu_valid = 1'b0;
  logic cpu_ready;
  ldb_addr_t cpu_addr = '0;
  ldb_data_t cpu_wdata = '0;
  logic cpu_write = 1'b0;
  logic cpu_io = 1'b0;
  logic lmem_en_n, lmem_write;
  ldb_addr_t lmem_addr;
  ldb_data_t lmem_wdata, lmem_rdata;
  logic bus_req, bus_dstb_n, bus_iorq_n, bus_wbd_n, bus_wlbd_n;
  logic bus_gnt = 1'b0;
  logic bus_rdy_n = 1'b1;
  ldb_addr_t bus_addr;
  ldb_data_t bus_wdata, bus_rdata;
  logic rsp_valid, rsp_err;
  logic rsp_ready = 1'b0;
  ldb_data_t rsp_rdata;

  ldb_data_t lmem [16384];  // Local memory model
  ldb_data_t bmem [65536];  // Bus memory model
  ldb_data_t iomem [65536]; // Bus IO model
  ldb_data_t ref_lmem [16384];  // Reference copies
  ldb_data_t ref_bmem [65536];
  ldb_data_t ref_io [65536];

  logic      q_write[$];  // Accepted, not yet answered
  logic      q_io[$];
  ldb_addr_t q_addr[$];
  ldb_data_t q_rdata[$];
  logic      q_err[$];

  logic [31:0] stim_rng = 32'h9544520a;
  logic [31:0] bus_rng;
  logic [31:0] bp_rng;
  logic        bp_on = 1'b0;  // Random rsp_ready stalls
  int          errors = 0;
  int          checks = 0;
  int          n_rsp = 0;
  int          n_acc = 0;
  logic [3:0]  gcnt, gdelay, rcnt, rdelay;

  always #CLK_HALF clk = ~clk;

  ldb_ctl_top u_ldb_ctl_top (.*);

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    stim_rng = xorshift(stim_rng);
    return stim_rng;
  endfunction

  // Fill patterns, each a function of the whole address
  function automatic ldb_data_t lmem_fill(input ldb_addr_t a);
    return (a * 16'h9e37) ^ 16'h1234;
  endfunction
  function automatic ldb_data_t bmem_fill(input ldb_addr_t a);
    return {a[7:0], a[15:8]} ^ 16'h5aa5;
  endfunction
  function automatic ldb_data_t io_fill(input ldb_addr_t a);
    return ~a + 16'h0101;
  endfunction

  // Expected {err, rdata} from decode and timeout rules
  function automatic logic [16:0] ref_cycle(input logic write, input logic io,
                                            input ldb_addr_t addr, input ldb_data_t wdata);
    logic [16:0] r;
    r = '0;
    if (!io && addr < `LDB_LMEM_TOP) begin
      if (write) ref_lmem[addr[13:0]] = wdata;
      else r[15:0] = ref_lmem[addr[13:0]];
    end else if (addr >= ABSENT_BASE) begin
      r[16] = 1'b1;  // Nobody answers, timeout
    end else if (io) begin
      if (write) ref_io[addr] = wdata;
      else r[15:0] = ref_io[addr];
    end else begin
      if (write) ref_bmem[addr] = wdata;
      else r[15:0] = ref_bmem[addr];
    end
    return r;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Offer one request, hold until accepted
  task automatic send(input logic write, input logic io, input ldb_addr_t addr,
                      input ldb_data_t wdata);
    logic [16:0] e;
    cpu_valid <= 1'b1;
    cpu_write <= write;
    cpu_io    <= io;
    cpu_addr  <= addr;
    cpu_wdata <= wdata;
    do @(posedge clk); while (!cpu_ready);
    e = ref_cycle(write, io, addr, wdata);
    q_write.push_back(write);
    q_io.push_back(io);
    q_addr.push_back(addr);
    q_rdata.push_back(e[15:0]);
    q_err.push_back(e[16]);
    n_acc++;
  endtask

  task automatic finish_test(input int num, input string name, input int err_before);
    cpu_valid <= 1'b0;
    while (q_addr.size() != 0) @(posedge clk);
    repeat (2) @(posedge clk);
    $display("test %0d %s done, %0d errors", num, name, errors - err_before);
  endtask

  // Local memory answers while enabled
  assign lmem_rdata = lmem[lmem_addr[13:0]];
  always @(posedge clk) begin
    if (!lmem_en_n && lmem_write) lmem[lmem_addr[13:0]] <= lmem_wdata;
  end

  // System bus target, IO space picked by the IO strobe
  assign bus_rdata = !bus_iorq_n ? iomem[bus_addr] : bmem[bus_addr];
  always @(posedge clk) begin
    if (!rst_n) begin
      bus_gnt   <= 1'b0;
      bus_rdy_n <= 1'b1;
      gcnt      <= '0;
      gdelay    <= '0;
      rcnt      <= '0;
      rdelay    <= '0;
    end else begin
      if (!bus_req) begin
        bus_gnt <= 1'b0;
        gcnt    <= '0;
        bus_rng = xorshift(bus_rng);
        gdelay  <= 4'(bus_rng[7:0] % MAX_GNT);
      end else if (!bus_gnt) begin
        if (gcnt >= gdelay) bus_gnt <= 1'b1;
        else gcnt <= gcnt + 1'b1;
      end
      if (!bus_rdy_n) begin
        bus_rdy_n <= 1'b1;  // Single ready pulse
        if (!bus_dstb_n && !bus_wbd_n) begin
          if (!bus_iorq_n) iomem[bus_addr] <= bus_wdata;
          else bmem[bus_addr] <= bus_wdata;
        end
      end else if (!bus_dstb_n) begin
        if (bus_addr < ABSENT_BASE) begin
          if (rcnt >= rdelay) bus_rdy_n <= 1'b0;
          else rcnt <= rcnt + 1'b1;
        end
      end else begin
        rcnt <= '0;
        bus_rng = xorshift(bus_rng ^ 32'h1);
        rdelay <= 4'(bus_rng[11:4] % MAX_RDY);
      end
    end
  end

  // Response back-pressure
  always @(posedge clk) begin
    if (!rst_n) begin
      rsp_ready <= 1'b0;
    end else if (bp_on) begin
      bp_rng = xorshift(bp_rng);
      rsp_ready <= bp_rng[3];
    end else begin
      rsp_ready <= 1'b1;
    end
  end

  // Comparison on every response transfer and on bus activity
  always @(posedge clk) begin
    if (rst_n && rsp_valid && rsp_ready) begin
      n_rsp++;
      if (q_addr.size() == 0) begin
        errors++;
        $display("Response arrived at %0t with no request outstanding", $time);
      end else begin
        check("rsp_rdata", rsp_rdata, q_rdata[0]);
        check("rsp_err", rsp_err, q_err[0]);
        void'(q_write.pop_front());
        void'(q_io.pop_front());
        void'(q_addr.pop_front());
        void'(q_rdata.pop_front());
        void'(q_err.pop_front());
      end
    end
    if (rst_n && !bus_dstb_n && q_addr.size() != 0) begin
      check("bus_addr", bus_addr, q_addr[0]);
      check("bus_iorq_n", bus_iorq_n, !q_io[0]);
      check("bus_wbd_n", bus_wbd_n, !q_write[0]);  // Low only for writes
      check("bus_wlbd_n", bus_wlbd_n, q_write[0]);
    end
    if (rst_n && bus_dstb_n) check("bus_iorq_n", bus_iorq_n, 1'b1);
    if (rst_n && !lmem_en_n) check("bus_req", bus_req, 1'b0);  // Local cycles stay off the bus
  end

  initial begin
    #(WDOG_CYC * 2 * CLK_HALF);
    $display("Run timed out after %0d cycles with responses still missing", WDOG_CYC);
    $display("Test FAILED");
    $finish;
  end

  initial begin
    ldb_addr_t addrs [16];
    logic [31:0] r;
    int e0;
    bus_rng = xorshift(32'h9544520a);
    bp_rng  = xorshift(bus_rng);
    for (int a = 0; a < 65536; a++) begin
      if (a < 16384) begin
        lmem[a]     = lmem_fill(ldb_addr_t'(a));
        ref_lmem[a] = lmem_fill(ldb_addr_t'(a));
      end
      bmem[a]     = bmem_fill(ldb_addr_t'(a));
      ref_bmem[a] = bmem_fill(ldb_addr_t'(a));
      iomem[a]    = io_fill(ldb_addr_t'(a));
      ref_io[a]   = io_fill(ldb_addr_t'(a));
    end
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    e0 = errors;  // Local writes then reads
    for (int i = 0; i < 8; i++) begin
      r = next_rand();
      addrs[i] = ldb_addr_t'(r[13:0]);
      send(1'b1, 1'b0, addrs[i], r[31:16]);
    end
    for (int i = 0; i < 8; i++) send(1'b0, 1'b0, addrs[i], '0);
    finish_test(1, "local memory", e0);

    e0 = errors;  // Bus memory, random delays
    for (int i = 0; i < 12; i++) begin
      r = next_rand();
      addrs[i] = 16'h4000 + ldb_addr_t'(r[15:0] % 16'hb000);
      send(1'b1, 1'b0, addrs[i], r[31:16]);
    end
    for (int i = 0; i < 12; i++) send(1'b0, 1'b0, addrs[(i * 5) % 12], '0);
    finish_test(2, "bus memory", e0);

    e0 = errors;  // IO space
    for (int i = 0; i < 6; i++) begin
      r = next_rand();
      addrs[i] = ldb_addr_t'(r[11:0]);
      send(1'b1, 1'b1, addrs[i], r[31:16]);
      send(1'b0, 1'b1, ldb_addr_t'(r[27:16]), '0);
    end
    for (int i = 0; i < 6; i++) send(1'b0, 1'b1, addrs[i], '0);
    finish_test(3, "bus io", e0);

    e0 = errors;  // Absent target, then a normal cycle
    for (int i = 0; i < 4; i++) begin
      r = next_rand();
      send(r[0], r[1], ABSENT_BASE | ldb_addr_t'(r[27:16]), r[15:0]);
      send(1'b0, 1'b0, 16'h8000 | ldb_addr_t'(r[14:2]), '0);
    end
    finish_test(4, "bus timeout", e0);

    e0 = errors;  // Mixed traffic under rsp_ready stalls
    bp_on <= 1'b1;
    for (int i = 0; i < 40; i++) begin
      r = next_rand();
      case (r[1:0])
        2'd0: send(r[2], 1'b0, ldb_addr_t'(r[29:16]), r[15:0]);
        2'd1: send(r[2], 1'b0, 16'h4000 + ldb_addr_t'(r[31:16] % 16'hb000), r[15:0]);
        2'd2: send(r[2], 1'b1, ldb_addr_t'(r[27:16]), r[15:0]);
        default: send(r[2], r[3], ABSENT_BASE | ldb_addr_t'(r[27:16]), r[15:0]);
      endcase
    end
    finish_test(5, "back-pressure order", e0);
    bp_on <= 1'b0;

    check("response count", n_rsp, n_acc);
    if (u_ldb_ctl_top.u_sva.n_fail != 0) begin
      errors += u_ldb_ctl_top.u_sva.n_fail;  // Bound protocol assertions
      $display("Protocol assertions failed %0d times", u_ldb_ctl_top.u_sva.n_fail);
    end
    $display("tests 5, requests %0d, checks %0d, errors %0d", n_acc, checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== sim/ldb_ctl_sva.sv ====
/*
  LDB controller bus protocol assertions
  Bound to the top level, watches strobe, direction and handshakes
*/
`timescale 1ns/1ps

module ldb_ctl_sva (
  input logic clk,
  input logic rst_n,
  input logic cpu_valid,
  input logic cpu_ready,
  input logic rsp_valid,
  input logic rsp_ready,
  input logic bus_gnt,
  input logic bus_dstb_n,
  input logic bus_wbd_n,
  input logic bus_wlbd_n,
  input logic lmem_en_n
);

  int n_fail = 0;  // Failed assertion count

  // No strobe without grant
  a_dstb_gnt: assert property (@(posedge clk) disable iff (!rst_n)
    !bus_dstb_n |-> bus_gnt) else begin
    n_fail++;
    $error("strobe driven without grant");
  end

  // Transceivers never drive against each other
  a_dir_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(!bus_wbd_n && !bus_wlbd_n)) else begin
    n_fail++;
    $error("both directions enabled");
  end

  a_path_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(!lmem_en_n && !bus_dstb_n)) else begin
    n_fail++;
    $error("local memory and bus strobe together");
  end

  // Handshakes hold until taken
  a_cpu_hold: assert property (@(posedge clk) disable iff (!rst_n)
    cpu_valid && !cpu_ready |=> cpu_valid) else begin
    n_fail++;
    $error("cpu_valid dropped early");
  end

  a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && !rsp_ready |=> rsp_valid) else begin
    n_fail++;
    $error("rsp_valid dropped early");
  end

endmodule

bind ldb_ctl_top ldb_ctl_sva u_sva (
  .clk        (clk),
  .rst_n      (rst_n),
  .cpu_valid  (cpu_valid),
  .cpu_ready  (cpu_ready),
  .rsp_valid  (rsp_valid),
  .rsp_ready  (rsp_ready),
  .bus_gnt    (bus_gnt),
  .bus_dstb_n (bus_dstb_n),
  .bus_wbd_n  (bus_wbd_n),
  .bus_wlbd_n (bus_wlbd_n),
  .lmem_en_n  (lmem_en_n)
);

// ==== logic/ldb_ctl_top.sv ====
/*
  LDB controller top level
  Decoder, cycle queue and bus cycle sequencer in a chain
*/
`timescale 1ns/1ps

module ldb_ctl_top (
  input  logic                clk,
  input  logic                rst_n,
  // CPU request
  input  logic                cpu_valid,
  output logic                cpu_ready,
  input  ldb_pkg::ldb_addr_t  cpu_addr,
  input  ldb_pkg::ldb_data_t  cpu_wdata,
  input  logic                cpu_write,
  input  logic                cpu_io,
  // Local memory
  output logic                lmem_en_n,
  output logic                lmem_write,
  output ldb_pkg::ldb_addr_t  lmem_addr,
  output ldb_pkg::ldb_data_t  lmem_wdata,
  input  ldb_pkg::ldb_data_t  lmem_rdata,
  // System bus
  output logic                bus_req,
  input  logic                bus_gnt,
  output logic                bus_dstb_n,
  output logic                bus_iorq_n,
  output logic                bus_wbd_n,
  output logic                bus_wlbd_n,
  output ldb_pkg::ldb_addr_t  bus_addr,
  output ldb_pkg::ldb_data_t  bus_wdata,
  input  logic                bus_rdy_n,
  input  ldb_pkg::ldb_data_t  bus_rdata,
  // Response
  output logic                rsp_valid,
  input  logic                rsp_ready,
  output ldb_pkg::ldb_data_t  rsp_rdata,
  output logic                rsp_err
);

  import ldb_pkg::*;

  logic        dec_valid;   // Decoder to queue
  logic        dec_ready;
  ldb_target_e dec_target;
  ldb_addr_t   dec_addr;
  ldb_data_t   dec_wdata;
  logic        dec_write;
  logic        cyc_valid;   // Queue to sequencer
  logic        cyc_ready;
  ldb_target_e cyc_target;
  ldb_addr_t   cyc_addr;
  ldb_data_t   cyc_wdata;
  logic        cyc_write;

  ldb_cycle_decode u_decode (
    .clk        (clk),
    .rst_n      (rst_n),
    .cpu_valid  (cpu_valid),
    .cpu_ready  (cpu_ready),
    .cpu_addr   (cpu_addr),
    .cpu_wdata  (cpu_wdata),
    .cpu_write  (cpu_write),
    .cpu_io     (cpu_io),
    .dec_valid  (dec_valid),
    .dec_ready  (dec_ready),
    .dec_target (dec_target),
    .dec_addr   (dec_addr),
    .dec_wdata  (dec_wdata),
    .dec_write  (dec_write)
  );

  ldb_cycle_queue u_queue (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (dec_valid),
    .in_ready   (dec_ready),
    .in_target  (dec_target),
    .in_addr    (dec_addr),
    .in_wdata   (dec_wdata),
    .in_write   (dec_write),
    .out_valid  (cyc_valid),
    .out_ready  (cyc_ready),
    .out_target (cyc_target),
    .out_addr   (cyc_addr),
    .out_wdata  (cyc_wdata),
    .out_write  (cyc_write)
  );

  ldb_bus_sequencer u_seq (
    .clk        (clk),
    .rst_n      (rst_n),
    .cyc_valid  (cyc_valid),
    .cyc_ready  (cyc_ready),
    .cyc_target (cyc_target),
    .cyc_addr   (cyc_addr),
    .cyc_wdata  (cyc_wdata),
    .cyc_write  (cyc_write),
    .lmem_en_n  (lmem_en_n),
    .lmem_write (lmem_write),
    .lmem_addr  (lmem_addr),
    .lmem_wdata (lmem_wdata),
    .lmem_rdata (lmem_rdata),
    .bus_req    (bus_req),
    .bus_gnt    (bus_gnt),
    .bus_dstb_n (bus_dstb_n),
    .bus_iorq_n (bus_iorq_n),
    .bus_wbd_n  (bus_wbd_n),
    .bus_wlbd_n (bus_wlbd_n),
    .bus_addr   (bus_addr),
    .bus_wdata  (bus_wdata),
    .bus_rdy_n  (bus_rdy_n),
    .bus_rdata  (bus_rdata),
    .rsp_valid  (rsp_valid),
    .rsp_ready  (rsp_ready),
    .rsp_rdata  (rsp_rdata),
    .rsp_err    (rsp_err)
  );

endmodule

// ==== logic/ldb_bus_sequencer.sv ====
/*
  LDB bus cycle sequencer
  Runs one queued cycle at a time on local memory or the system bus
  and returns read data with an error flag per cycle
*/
`timescale 1ns/1ps
`include "ldb_settings.svh"

module ldb_bus_sequencer (
  input  logic                  clk,
  input  logic                  rst_n,
  // Queued cycle in
  input  logic                  cyc_valid,
  output logic                  cyc_ready,
  input  ldb_pkg::ldb_target_e  cyc_target,
  input  ldb_pkg::ldb_addr_t    cyc_addr,
  input  ldb_pkg::ldb_data_t    cyc_wdata,
  input  logic                  cyc_write,
  // Local memory
  output logic                  lmem_en_n,
  output logic                  lmem_write,
  output ldb_pkg::ldb_addr_t    lmem_addr,
  output ldb_pkg::ldb_data_t    lmem_wdata,
  input  ldb_pkg::ldb_data_t    lmem_rdata,
  // System bus
  output logic                  bus_req,
  input  logic                  bus_gnt,
  output logic                  bus_dstb_n,
  output logic                  bus_iorq_n,
  output logic                  bus_wbd_n,
  output logic                  bus_wlbd_n,
  output ldb_pkg::ldb_addr_t    bus_addr,
  output ldb_pkg::ldb_data_t    bus_wdata,
  input  logic                  bus_rdy_n,
  input  ldb_pkg::ldb_data_t    bus_rdata,
  // Response to CPU
  output logic                  rsp_valid,
  input  logic                  rsp_ready,
  output ldb_pkg::ldb_data_t    rsp_rdata,
  output logic                  rsp_err
);

  import ldb_pkg::*;

  localparam int CNT_MAX = (`LDB_BUS_TIMEOUT > `LDB_LMEM_WAIT) ?
                           `LDB_BUS_TIMEOUT : `LDB_LMEM_WAIT;
  localparam int CNT_W   = $clog2(CNT_MAX + 1);
  localparam logic [CNT_W-1:0] LMEM_LAST = CNT_W'(`LDB_LMEM_WAIT - 1);
  localparam logic [CNT_W-1:0] TMO_LAST  = CNT_W'(`LDB_BUS_TIMEOUT - 1);

  ldb_seq_state_e   state;
  logic [CNT_W-1:0] cnt;         // Wait or timeout count
  logic             take;        // Cycle accepted from queue
  logic             dstb_q;      // Strobe wanted
  logic             strobe_on;   // Strobe actually on the bus
  ldb_target_e      cur_target;  // Held for the whole cycle
  ldb_addr_t        cur_addr;
  ldb_data_t        cur_wdata;
  logic             cur_write;

  assign cyc_ready = (state == st_idle);
  assign take      = cyc_valid & cyc_ready;

  // Address, data and direction stay on both paths
  assign lmem_write = cur_write;
  assign lmem_addr  = cur_addr;
  assign lmem_wdata = cur_wdata;
  assign bus_addr   = cur_addr;
  assign bus_wdata  = cur_wdata;

  // Strobe only while granted, transceiver direction follows it
  assign strobe_on  = dstb_q & bus_gnt;
  assign bus_dstb_n = ~strobe_on;
  assign bus_iorq_n = ~(strobe_on & (cur_target == tgt_bus_io));
  assign bus_wbd_n  = ~(strobe_on & cur_write);   // Local bus to system bus
  assign bus_wlbd_n = ~(strobe_on & ~cur_write);  // System bus to local bus

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= st_idle;
      cnt       <= '0;
      bus_req   <= 1'b0;
      dstb_q    <= 1'b0;
      lmem_en_n <= 1'b1;
      rsp_valid <= 1'b0;
      rsp_err   <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (take) begin
            cnt     <= '0;
            rsp_err <= 1'b0;
            if (cyc_target == tgt_lmem) begin
              lmem_en_n <= 1'b0;  // Local memory onto data path
              state     <= st_lmem;
            end else begin
              bus_req <= 1'b1;  // Ask arbiter for the bus
              state   <= st_req;
            end
          end
        end
        st_lmem: begin
          if (cnt == LMEM_LAST) begin
            lmem_en_n <= 1'b1;  // Wait count done
            rsp_valid <= 1'b1;
            state     <= st_resp;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        st_req: begin
          if (bus_gnt) begin
            dstb_q <= 1'b1;  // Strobe from next cycle
            cnt    <= '0;
            state  <= st_strobe;
          end
        end
        st_strobe: begin
          if (!bus_rdy_n) begin
            dstb_q    <= 1'b0;  // Target answered
            bus_req   <= 1'b0;
            rsp_valid <= 1'b1;
            state     <= st_resp;
          end else if (cnt == TMO_LAST) begin
            dstb_q    <= 1'b0;  // No target, give up
            bus_req   <= 1'b0;
            rsp_valid <= 1'b1;
            rsp_err   <= 1'b1;
            state     <= st_resp;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        st_resp: begin
          if (rsp_ready) begin
            rsp_valid <= 1'b0;  // Transferred, free for next cycle
            state     <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Cycle payload and response data
  always_ff @(posedge clk) begin
    if (take) begin
      cur_target <= cyc_target;
      cur_addr   <= cyc_addr;
      cur_wdata  <= cyc_wdata;
      cur_write  <= cyc_write;
    end
    if (state == st_lmem && cnt == LMEM_LAST) begin
      rsp_rdata <= cur_write ? '0 : lmem_rdata;  // Sampled on last wait cycle
    end
    if (state == st_strobe) begin
      if (!bus_rdy_n) begin
        rsp_rdata <= cur_write ? '0 : bus_rdata;
      end else if (cnt == TMO_LAST) begin
        rsp_rdata <= '0;  // Nothing valid on timeout
      end
    end
  end

endmodule

// ==== logic/ldb_cycle_queue.sv ====
/*
  LDB cycle queue
  Circular FIFO of decoded cycles, valid/ready on both sides
*/
`timescale 1ns/1ps
`include "ldb_settings.svh"

module ldb_cycle_queue (
  input  logic                  clk,
  input  logic                  rst_n,
  // Write side from decoder
  input  logic                  in_valid,
  output logic                  in_ready,
  input  ldb_pkg::ldb_target_e  in_target,
  input  ldb_pkg::ldb_addr_t    in_addr,
  input  ldb_pkg::ldb_data_t    in_wdata,
  input  logic                  in_write,
  // Read side to sequencer
  output logic                  out_valid,
  input  logic                  out_ready,
  output ldb_pkg::ldb_target_e  out_target,
  output ldb_pkg::ldb_addr_t    out_addr,
  output ldb_pkg::ldb_data_t    out_wdata,
  output logic                  out_write
);

  import ldb_pkg::*;

  localparam int DEPTH = `LDB_QUEUE_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH);

  ldb_target_e target_mem [DEPTH];  // Entry storage
  ldb_addr_t   addr_mem   [DEPTH];
  ldb_data_t   wdata_mem  [DEPTH];
  logic        write_mem  [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;  // Occupancy
  logic             push;
  logic             pop;

  assign in_ready  = (count != CNT_FULL);  // Stall decoder when full
  assign out_valid = (count != '0);
  assign push      = in_valid & in_ready;
  assign pop       = out_valid & out_ready;

  // Head entry straight from storage
  assign out_target = target_mem[rd_ptr];
  assign out_addr   = addr_mem[rd_ptr];
  assign out_wdata  = wdata_mem[rd_ptr];
  assign out_write  = write_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;  // Wrap at depth
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_LAST) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      target_mem[wr_ptr] <= in_target;
      addr_mem[wr_ptr]   <= in_addr;
      wdata_mem[wr_ptr]  <= in_wdata;
      write_mem[wr_ptr]  <= in_write;
    end
  end

endmodule

// ==== logic/ldb_cycle_decode.sv ====
/*
  LDB cycle decoder
  Accepts CPU cycle requests and classifies them as local memory,
  bus memory or bus IO into a one-entry output register
*/
`timescale 1ns/1ps
`include "ldb_settings.svh"

module ldb_cycle_decode (
  input  logic                  clk,
  input  logic                  rst_n,
  // CPU request
  input  logic                  cpu_valid,
  output logic                  cpu_ready,
  input  ldb_pkg::ldb_addr_t    cpu_addr,
  input  ldb_pkg::ldb_data_t    cpu_wdata,
  input  logic                  cpu_write,
  input  logic                  cpu_io,
  // Decoded cycle out
  output logic                  dec_valid,
  input  logic                  dec_ready,
  output ldb_pkg::ldb_target_e  dec_target,
  output ldb_pkg::ldb_addr_t    dec_addr,
  output ldb_pkg::ldb_data_t    dec_wdata,
  output logic                  dec_write
);

  import ldb_pkg::*;

  ldb_target_e target_c;  // Target of the offered request
  logic        accept;    // CPU transfer this edge
  logic        ready_en;  // Low during and just after reset

  // IO flag wins, then the local window
  always_comb begin
    if (cpu_io) begin
      target_c = tgt_bus_io;
    end else if (cpu_addr < `LDB_LMEM_TOP) begin
      target_c = tgt_lmem;
    end else begin
      target_c = tgt_bus_mem;
    end
  end

  // Room when empty or draining this cycle
  assign cpu_ready = ready_en & (~dec_valid | dec_ready);
  assign accept    = cpu_valid & cpu_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ready_en  <= 1'b0;
      dec_valid <= 1'b0;
    end else begin
      ready_en <= 1'b1;  // Open one cycle after reset
      if (accept) begin
        dec_valid <= 1'b1;  // New entry replaces any drained one
      end else if (dec_ready) begin
        dec_valid <= 1'b0;  // Drained, nothing new
      end
    end
  end

  // Payload register, loaded on accept only
  always_ff @(posedge clk) begin
    if (accept) begin
      dec_target <= target_c;
      dec_addr   <= cpu_addr;
      dec_wdata  <= cpu_wdata;
      dec_write  <= cpu_write;
    end
  end

endmodule

// ==== logic/ldb_pkg.sv ====
/*
  LDB controller types
  Address and data vectors, cycle target and sequencer state encodings
*/
`include "ldb_settings.svh"

package ldb_pkg;

  // Local data bus address
  typedef logic [`LDB_ADDR_W-1:0] ldb_addr_t;

  // Local data bus data word
  typedef logic [`LDB_DATA_W-1:0] ldb_data_t;

  // Where a decoded cycle goes
  typedef enum logic [1:0] {
    tgt_lmem    = 2'd0,  // Fast local memory
    tgt_bus_mem = 2'd1,  // Remote memory on system bus
    tgt_bus_io  = 2'd2   // IO device on system bus
  } ldb_target_e;

  // Bus cycle sequencer
  typedef enum logic [2:0] {
    st_idle   = 3'd0,  // Waiting for a queued cycle
    st_lmem   = 3'd1,  // Local memory enabled
    st_req    = 3'd2,  // Bus requested, waiting grant
    st_strobe = 3'd3,  // Data strobe out, waiting ready
    st_resp   = 3'd4   // Response offered to CPU
  } ldb_seq_state_e;

endpackage

// ==== logic/ldb_settings.svh ====
/*
  LDB controller build settings
  Bus widths, local memory window, local wait and bus timeout counts
*/
`ifndef LDB_SETTINGS_SVH
`define LDB_SETTINGS_SVH

// Address and data path widths
`define LDB_ADDR_W 16
`define LDB_DATA_W 16

// First address above the local memory window
`define LDB_LMEM_TOP 16'h4000

// Cycles the local memory enable is held
`define LDB_LMEM_WAIT 2

// Strobe cycles without bus ready before error
`define LDB_BUS_TIMEOUT 16

// Posted cycle queue depth
`define LDB_QUEUE_DEPTH 4

`endif
